// ==== src/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Build-time sizing of the teaching core

// Instruction words in program storage, sets the pc width
`define CPU_IMEM_DEPTH 64

// General purpose registers, sets the register index width
`define CPU_REG_COUNT 32

// Datapath width of registers, ALU and displays
`define CPU_WORD_WIDTH 32

`endif

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

	`include "cpu_config.svh"

	localparam int word_width = `CPU_WORD_WIDTH; // Datapath width
	localparam int pc_width = $clog2(`CPU_IMEM_DEPTH); // Word address bits
	localparam int reg_idx_width = $clog2(`CPU_REG_COUNT); // Register index bits

	typedef logic [word_width-1:0] word_t; // Register and bus word
	typedef logic [pc_width-1:0] pc_t; // Instruction word address
	typedef logic [reg_idx_width-1:0] reg_idx_t; // Register index
	typedef logic [15:0] imm_t; // Immediate field

	// Opcode field, bits 31:26 of the instruction
	typedef enum logic [5:0] {
		OP_NOP  = 6'b000000,
		OP_ADD  = 6'b000001, // rd = rs + rt
		OP_ADDI = 6'b000010, // rt = rs + sext(imm)
		OP_SUB  = 6'b000011, // rd = rs - rt
		OP_LI   = 6'b010100, // rt = zext(imm)
		OP_IN   = 6'b100000, // rt = in_data
		OP_OUT  = 6'b100001, // display[rd] = rt
		OP_JUMP = 6'b100101, // Absolute target in imm
		OP_BNE  = 6'b100111,
		OP_BEQ  = 6'b101000,
		OP_HALT = 6'b111111
	} opcode_t;

	// Decoder output, fields plus control flags
	typedef struct packed {
		opcode_t opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		imm_t immediate;
		reg_idx_t dest; // rd for R-type, rt for immediate forms
		logic reg_write; // Instruction writes dest
		logic is_in; // Write-back from input port
		logic is_out; // Display update
		logic is_branch; // Conditional branch
		logic branch_on_equal; // BEQ when set, BNE when clear
		logic is_jump; // Unconditional jump
		logic is_halt; // Stops the core
	} decoded_instr_t;

	// Execute stage output
	typedef struct packed {
		word_t alu_value; // Sum or difference
		pc_t next_pc; // Target or pc+1
		logic branch_taken; // Condition held
	} exec_result_t;

	// Three output display words
	typedef struct packed {
		word_t d0;
		word_t d1;
		word_t d2;
	} display_set_t;

endpackage

// ==== src/instruction_memory.sv ====
`timescale 1ns/1ns

`include "cpu_config.svh"

// Program storage, written by the loader and read at the program counter
module instruction_memory
	import cpu_pkg::*;
(
	input  logic  clock,
	input  logic  prog_we, // Load strobe
	input  pc_t   prog_addr, // Load word address
	input  word_t prog_data, // Load word
	input  pc_t   pc, // Fetch address
	output word_t instruction // Fetched word
);

	word_t mem [`CPU_IMEM_DEPTH]; // No reset on contents

	// One word per strobed clock
	always_ff @(posedge clock) begin
		if (prog_we) begin
			mem[prog_addr] <= prog_data;
		end
	end

	// Asynchronous fetch, single-cycle core
	assign instruction = mem[pc];

endmodule

// ==== src/instruction_decode.sv ====
`timescale 1ns/1ns

// Field extraction and control flag generation
module instruction_decode
	import cpu_pkg::*;
(
	input  word_t          instruction, // Fetched word
	output decoded_instr_t decoded // Fields and flags
);

	always_comb begin
		// Raw fields, same positions for every format
		decoded.opcode = opcode_t'(instruction[31:26]);
		decoded.rs = instruction[25:21];
		decoded.rt = instruction[20:16];
		decoded.rd = instruction[15:11];
		decoded.immediate = instruction[15:0];

		// Defaults behave as NOP
		decoded.dest = '0;
		decoded.reg_write = 1'b0;
		decoded.is_in = 1'b0;
		decoded.is_out = 1'b0;
		decoded.is_branch = 1'b0;
		decoded.branch_on_equal = 1'b0;
		decoded.is_jump = 1'b0;
		decoded.is_halt = 1'b0;

		case (decoded.opcode)
			OP_ADD, OP_SUB: begin
				decoded.dest = decoded.rd; // Three-register form
				decoded.reg_write = 1'b1;
			end
			OP_ADDI, OP_LI: begin
				decoded.dest = decoded.rt; // Immediate form
				decoded.reg_write = 1'b1;
			end
			OP_IN: begin
				decoded.dest = decoded.rt;
				decoded.reg_write = 1'b1;
				decoded.is_in = 1'b1; // Value from in_data
			end
			OP_OUT: begin
				decoded.is_out = 1'b1; // Selector in rd
			end
			OP_BEQ: begin
				decoded.is_branch = 1'b1;
				decoded.branch_on_equal = 1'b1;
			end
			OP_BNE: begin
				decoded.is_branch = 1'b1;
			end
			OP_JUMP: begin
				decoded.is_jump = 1'b1;
			end
			OP_HALT: begin
				decoded.is_halt = 1'b1;
			end
			default: begin
				// NOP and unknown codes keep all flags clear
			end
		endcase
	end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ns

`include "cpu_config.svh"

// General register bank, two combinational reads and one write
module register_file
	import cpu_pkg::*;
(
	input  logic     clock,
	input  logic     rst_n,
	input  reg_idx_t rs, // Read port A index
	input  reg_idx_t rt, // Read port B index
	output word_t    rs_value, // Read port A data
	output word_t    rt_value, // Read port B data
	input  logic     write_enable, // Retire-qualified write
	input  reg_idx_t write_index,
	input  word_t    write_value
);

	word_t regs [`CPU_REG_COUNT]; // Architectural registers

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0; // All registers cleared
			end
		end else if (write_enable && (write_index != '0)) begin
			regs[write_index] <= write_value; // r0 writes dropped
		end
	end

	// r0 hardwired to zero
	assign rs_value = (rs == '0) ? '0 : regs[rs];
	assign rt_value = (rt == '0) ? '0 : regs[rt];

endmodule

// ==== src/execute_unit.sv ====
`timescale 1ns/1ns

// ALU, branch compare and next-PC selection
module execute_unit
	import cpu_pkg::*;
(
	input  decoded_instr_t decoded,
	input  word_t          rs_value, // First operand
	input  word_t          rt_value, // Second operand, compare partner
	input  pc_t            pc, // Current instruction address
	output exec_result_t   result
);

	word_t imm_sext; // Sign-extended immediate for ADDI
	logic operands_equal; // Branch comparison
	logic redirect; // Taken branch or jump

	assign imm_sext = {{(word_width-16){decoded.immediate[15]}}, decoded.immediate};
	assign operands_equal = (rs_value == rt_value);

	// Arithmetic, wraps modulo 2^32
	always_comb begin
		case (decoded.opcode)
			OP_ADD: result.alu_value = rs_value + rt_value;
			OP_SUB: result.alu_value = rs_value - rt_value;
			OP_ADDI: result.alu_value = rs_value + imm_sext;
			default: result.alu_value = '0; // Unused by other opcodes
		endcase
	end

	// BEQ on equal, BNE on differ
	assign result.branch_taken = decoded.is_branch &&
		(decoded.branch_on_equal ? operands_equal : !operands_equal);

	assign redirect = result.branch_taken || decoded.is_jump;

	// Absolute target from the low immediate bits
	assign result.next_pc = redirect ? decoded.immediate[pc_width-1:0] : pc + 1'b1;

endmodule

// ==== src/result_stage.sv ====
`timescale 1ns/1ns

// Architectural state and retirement of each instruction
module result_stage
	import cpu_pkg::*;
(
	input  logic           clock,
	input  logic           rst_n,
	input  logic           run, // Execution enable level
	input  decoded_instr_t decoded,
	input  exec_result_t   result,
	input  word_t          rt_value, // Source for OUT
	input  word_t          in_data, // Sampled on IN retire
	output pc_t            pc,
	output logic           write_enable, // To register file
	output reg_idx_t       write_index,
	output word_t          write_value,
	output display_set_t   displays,
	output logic           in_read, // Pulse after IN retires
	output logic           halted
);

	logic retire; // Instruction completes this edge
	word_t imm_zext; // LI operand

	assign retire = run && !halted;
	assign imm_zext = {{(word_width-16){1'b0}}, decoded.immediate};

	// Write-back source select
	always_comb begin
		if (decoded.is_in) begin
			write_value = in_data;
		end else if (decoded.opcode == OP_LI) begin
			write_value = imm_zext;
		end else begin
			write_value = result.alu_value; // ADD, SUB, ADDI
		end
	end

	assign write_enable = retire && decoded.reg_write;
	assign write_index = decoded.dest;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			displays <= '0;
			in_read <= 1'b0;
			halted <= 1'b0;
		end else begin
			in_read <= retire && decoded.is_in; // One cycle per IN
			if (retire) begin
				pc <= result.next_pc;
				if (decoded.is_halt) begin
					halted <= 1'b1; // Freezes everything until reset
				end
				if (decoded.is_out) begin
					case (decoded.rd[1:0])
						2'd0: displays.d0 <= rt_value;
						2'd1: displays.d1 <= rt_value;
						2'd2: displays.d2 <= rt_value;
						default: begin
							// Selector 3 has no display
						end
					endcase
				end
			end
		end
	end

endmodule

// ==== src/cpu_top.sv ====
`timescale 1ns/1ns

// Single-cycle core, program loaded through the write strobe
module cpu_top
	import cpu_pkg::*;
(
	input  logic         clock,
	input  logic         rst_n,
	input  logic         run, // Low while loading
	input  logic         prog_we, // Program write strobe
	input  pc_t          prog_addr,
	input  word_t        prog_data,
	input  word_t        in_data, // Input port value
	output display_set_t displays, // d0, d1, d2
	output logic         in_read, // Input consumed
	output logic         halted
);

	pc_t pc; // Fetch address
	word_t instruction;
	decoded_instr_t decoded;
	word_t rs_value;
	word_t rt_value;
	exec_result_t result;
	logic write_enable;
	reg_idx_t write_index;
	word_t write_value;

	instruction_memory u_imem (
		.clock       (clock),
		.prog_we     (prog_we),
		.prog_addr   (prog_addr),
		.prog_data   (prog_data),
		.pc          (pc),
		.instruction (instruction)
	);

	instruction_decode u_decode (
		.instruction (instruction),
		.decoded     (decoded)
	);

	register_file u_regs (
		.clock        (clock),
		.rst_n        (rst_n),
		.rs           (decoded.rs),
		.rt           (decoded.rt),
		.rs_value     (rs_value),
		.rt_value     (rt_value),
		.write_enable (write_enable),
		.write_index  (write_index),
		.write_value  (write_value)
	);

	execute_unit u_exec (
		.decoded  (decoded),
		.rs_value (rs_value),
		.rt_value (rt_value),
		.pc       (pc),
		.result   (result)
	);

	// Retire logic and architectural state
	result_stage u_result (
		.clock        (clock),
		.rst_n        (rst_n),
		.run          (run),
		.decoded      (decoded),
		.result       (result),
		.rt_value     (rt_value),
		.in_data      (in_data),
		.pc           (pc),
		.write_enable (write_enable),
		.write_index  (write_index),
		.write_value  (write_value),
		.displays     (displays),
		.in_read      (in_read),
		.halted       (halted)
	);

endmodule

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ns

`include "cpu_config.svh"

// Testbench for the single-cycle core, checked against a lockstep reference model
module cpu_tb
	import cpu_pkg::*;
();

	localparam int clock_period = 20;
	localparam int program_count = 6; // Reset check plus five programs
	localparam int watchdog_cycles = 200 * program_count;
	localparam int halt_linger = 6; // Cycles watched after HALT

	logic clock;
	logic rst_n;
	logic run;
	logic prog_we;
	pc_t prog_addr;
	word_t prog_data;
	word_t in_data;
	display_set_t displays;
	logic in_read;
	logic halted;

	word_t model_mem [`CPU_IMEM_DEPTH]; // Mirror of loaded program
	word_t model_regs [`CPU_REG_COUNT];
	pc_t model_pc;
	display_set_t model_displays;
	logic model_in_read; // Expected pulse after the coming edge
	logic model_halted;

	word_t program_words [$]; // Program being built
	word_t input_values [$]; // Values for IN, in order
	word_t rand_a;
	word_t rand_b;
	word_t rand_c;
	int fib_count;

	cpu_top u_dut (
		.clock     (clock),
		.rst_n     (rst_n),
		.run       (run),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.in_data   (in_data),
		.displays  (displays),
		.in_read   (in_read),
		.halted    (halted)
	);

	always #(clock_period / 2) clock = ~clock;

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "Run stopped at first failure");
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		assert (actual === expected) else begin
			$display("ERROR: time %0t signal %s expected %h actual %h", $time, name,
				expected, actual);
			abort_run();
		end
	endtask

	// Nothing moves once halted, until reset
	assert property (@(posedge clock) disable iff (!rst_n)
		halted |=> (!rst_n || (halted && !in_read && $stable(displays))))
		else begin
			$display("Core state changed after HALT at time %0t", $time);
			abort_run();
		end

	// Loading with run low leaves state alone
	assert property (@(posedge clock) disable iff (!rst_n)
		!run |=> (!rst_n || ($stable(displays) && $stable(halted) && !in_read)))
		else begin
			$display("Core state changed while run was low at time %0t", $time);
			abort_run();
		end

	function automatic word_t reg_op(opcode_t op, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
		return {op, rs, rt, rd, 11'b0};
	endfunction

	function automatic word_t imm_op(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t fibonacci(int count);
		word_t a;
		word_t b;
		word_t t;
		a = 0;
		b = 1;
		for (int i = 0; i < count; i++) begin
			t = a + b;
			a = b;
			b = t;
		end
		return a;
	endfunction

	task automatic write_model_reg(input reg_idx_t index, input word_t value);
		if (index != 0) begin
			model_regs[index] = value; // r0 stays zero
		end
	endtask

	// One retire of the model, taken on the coming edge
	task automatic model_step();
		word_t word;
		logic [5:0] op;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		imm_t imm;
		pc_t next_pc;
		model_in_read = 1'b0;
		if (!run || model_halted) begin
			return;
		end
		word = model_mem[model_pc];
		op = word[31:26];
		rs = word[25:21];
		rt = word[20:16];
		rd = word[15:11];
		imm = word[15:0];
		next_pc = model_pc + 1'b1;
		case (op)
			OP_ADD: write_model_reg(rd, model_regs[rs] + model_regs[rt]);
			OP_SUB: write_model_reg(rd, model_regs[rs] - model_regs[rt]);
			OP_ADDI: write_model_reg(rt, model_regs[rs] + {{16{imm[15]}}, imm});
			OP_LI: write_model_reg(rt, {16'h0000, imm});
			OP_IN: begin
				write_model_reg(rt, in_data);
				model_in_read = 1'b1;
			end
			OP_OUT: begin
				if (rd[1:0] == 2'd0) model_displays.d0 = model_regs[rt];
				if (rd[1:0] == 2'd1) model_displays.d1 = model_regs[rt];
				if (rd[1:0] == 2'd2) model_displays.d2 = model_regs[rt]; // 3 ignored
			end
			OP_BEQ: if (model_regs[rs] == model_regs[rt]) next_pc = imm[pc_width-1:0];
			OP_BNE: if (model_regs[rs] != model_regs[rt]) next_pc = imm[pc_width-1:0];
			OP_JUMP: next_pc = imm[pc_width-1:0];
			OP_HALT: model_halted = 1'b1;
			default: ; // NOP and unknown codes
		endcase
		model_pc = next_pc;
	endtask

	task automatic check_state();
		check_value("halted", {31'b0, model_halted}, {31'b0, halted});
		check_value("in_read", {31'b0, model_in_read}, {31'b0, in_read});
		check_value("displays.d0", model_displays.d0, displays.d0);
		check_value("displays.d1", model_displays.d1, displays.d1);
		check_value("displays.d2", model_displays.d2, displays.d2);
	endtask

	// Whole memory written, unused words are HALT tagged with their address
	task automatic load_program();
		word_t word;
		for (int addr = 0; addr < `CPU_IMEM_DEPTH; addr++) begin
			word = (addr < program_words.size()) ? program_words[addr] :
				{OP_HALT, 10'b0, 16'(addr)};
			@(posedge clock);
			#2;
			prog_we = 1'b1;
			prog_addr = pc_t'(addr);
			prog_data = word;
			model_mem[addr] = word;
		end
		@(posedge clock);
		#2;
		prog_we = 1'b0;
		check_state(); // Old state kept through loading
	endtask

	task automatic reset_dut();
		@(posedge clock);
		#2;
		rst_n = 1'b0;
		run = 1'b0;
		repeat (10) @(posedge clock);
		#2;
		rst_n = 1'b1;
		for (int i = 0; i < `CPU_REG_COUNT; i++) begin
			model_regs[i] = '0;
		end
		model_pc = '0;
		model_displays = '0;
		model_in_read = 1'b0;
		model_halted = 1'b0;
	endtask

	// Runs from pc 0 until halted, then watches a few frozen cycles
	task automatic run_program();
		int linger;
		linger = 0;
		in_data = (input_values.size() > 0) ? input_values.pop_front() : '0;
		run = 1'b1;
		model_step();
		while (linger < halt_linger) begin
			@(posedge clock);
			#2;
			check_state();
			if (in_read && input_values.size() > 0) begin
				in_data = input_values.pop_front(); // Next value after each read
			end
			if (halted) begin
				linger++;
			end
			model_step();
		end
		run = 1'b0;
	endtask

	task automatic fib_program(input int count);
		program_words.delete();
		program_words.push_back(imm_op(OP_IN, 0, 1, 0)); // r1 = loop count
		program_words.push_back(imm_op(OP_LI, 0, 2, 0));
		program_words.push_back(imm_op(OP_LI, 0, 3, 1));
		program_words.push_back(imm_op(OP_BEQ, 1, 0, 9)); // Early exit on zero
		program_words.push_back(reg_op(OP_ADD, 2, 3, 4));
		program_words.push_back(reg_op(OP_ADD, 3, 0, 2));
		program_words.push_back(reg_op(OP_ADD, 4, 0, 3));
		program_words.push_back(imm_op(OP_ADDI, 1, 1, 16'hffff)); // Count down
		program_words.push_back(imm_op(OP_BNE, 1, 0, 4));
		program_words.push_back(reg_op(OP_OUT, 0, 2, 2));
		program_words.push_back(imm_op(OP_JUMP, 0, 0, 12));
		program_words.push_back(reg_op(OP_OUT, 0, 0, 2)); // Skipped by JUMP
		program_words.push_back(reg_op(OP_OUT, 0, 3, 1));
		program_words.push_back(imm_op(OP_HALT, 0, 0, 0));
		input_values.delete();
		input_values.push_back(count);
		load_program();
		reset_dut();
		run_program();
		check_value("displays.d2", fibonacci(count), displays.d2);
		check_value("displays.d1", fibonacci(count + 1), displays.d1);
	endtask

	initial begin
		#(watchdog_cycles * clock_period);
		$display("Watchdog expired before all programs finished");
		abort_run();
	end

	initial begin
		void'($urandom(32'h0c6a_608f));
		clock = 1'b0;
		rst_n = 1'b0;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		in_data = '0;
		reset_dut();
		check_state(); // Clean state after reset

		// IN, OUT and ADD
		rand_a = $urandom();
		rand_b = $urandom();
		program_words = {imm_op(OP_IN, 0, 1, 0), reg_op(OP_OUT, 0, 1, 0),
			imm_op(OP_IN, 0, 2, 0), reg_op(OP_OUT, 0, 2, 1), reg_op(OP_ADD, 1, 2, 3),
			reg_op(OP_OUT, 0, 3, 2), imm_op(OP_HALT, 0, 0, 0)};
		input_values = {rand_a, rand_b};
		load_program();
		reset_dut();
		run_program();
		check_value("displays.d2", rand_a + rand_b, displays.d2);

		// LI, ADDI with both immediate signs, SUB wrap, OUT selector 3
		rand_a = {16'h0000, 16'h8000 | 16'($urandom())}; // Top bit set, zero extension shows
		rand_b = {16'hffff, 16'h8000 | 16'($urandom())};
		rand_c = {16'h0000, 16'h7fff & 16'($urandom())}; // Positive ADDI operand
		program_words = {imm_op(OP_LI, 0, 1, rand_a[15:0]),
			imm_op(OP_ADDI, 1, 2, rand_b[15:0]), reg_op(OP_SUB, 0, 1, 4),
			imm_op(OP_ADDI, 0, 5, 16'h8000), imm_op(OP_ADDI, 2, 7, rand_c[15:0]),
			reg_op(OP_SUB, 5, 7, 6),
			reg_op(OP_OUT, 0, 2, 0), reg_op(OP_OUT, 0, 4, 1), reg_op(OP_OUT, 0, 6, 2),
			reg_op(OP_OUT, 0, 1, 3), imm_op(OP_HALT, 0, 0, 0)};
		input_values.delete();
		load_program();
		reset_dut();
		run_program();
		check_value("displays.d0", rand_a + rand_b, displays.d0);
		check_value("displays.d1", 32'h0 - rand_a, displays.d1);
		check_value("displays.d2", 32'hffff8000 - (rand_a + rand_b + rand_c), displays.d2);

		// Fibonacci loop, random count then the zero shortcut
		fib_count = 2 + ($urandom() % 19);
		fib_program(fib_count);
		fib_program(0);

		// HALT with code behind it, r0 write dropped
		rand_a = {16'h0000, 16'h0001 | 16'($urandom())}; // Nonzero so stray OUTs show
		program_words = {imm_op(OP_LI, 0, 0, 16'h1234), reg_op(OP_OUT, 0, 0, 0),
			imm_op(OP_LI, 0, 1, rand_a[15:0]), reg_op(OP_OUT, 0, 1, 1),
			imm_op(OP_HALT, 0, 0, 0), reg_op(OP_OUT, 0, 1, 2), imm_op(OP_IN, 0, 2, 0),
			reg_op(OP_OUT, 0, 1, 0), imm_op(OP_HALT, 0, 0, 0)};
		input_values = {32'($urandom())};
		load_program();
		reset_dut();
		run_program();
		check_value("displays.d0", 32'h0, displays.d0);
		check_value("displays.d1", rand_a, displays.d1);
		check_value("displays.d2", 32'h0, displays.d2);

		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+src
src/cpu_pkg.sv
src/instruction_memory.sv
src/instruction_decode.sv
src/register_file.sv
src/execute_unit.sv
src/result_stage.sv
src/cpu_top.sv
bench/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_teaching_core

sources:
  - include_dirs:
      - src
    files:
      - src/cpu_pkg.sv
      - src/instruction_memory.sv
      - src/instruction_decode.sv
      - src/register_file.sv
      - src/execute_unit.sv
      - src/result_stage.sv
      - src/cpu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/cpu_tb.sv
